//--- src/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// datapath widths
`define MEM_DATA_W 32
`define MEM_REG_AW 5

// CSR numbers that a TLB search reads implicitly
`define CSR_ASID   14'h18
`define CSR_TLBEHI 14'h11

`endif

//--- src/csr_pkg.sv
`default_nettype none

`include "mem_config.svh"

package csr_pkg;

    typedef logic [13:0] csr_num_t;

    typedef struct packed {
        logic                   we;
        logic                   re;
        csr_num_t               num;
        logic [`MEM_DATA_W-1:0] wmask;
        logic [`MEM_DATA_W-1:0] wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic                   ex;        // any exception on this item
        logic                   ertn;
        logic                   syscall;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`MEM_DATA_W-1:0] badv;      // faulting address
    } exc_t;

endpackage

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    // bit 2 set means zero extend, bits 1:0 give the size
    typedef enum logic [2:0] {
        MEM_NONE = 3'b000,
        MEM_H    = 3'b001,
        MEM_B    = 3'b010,
        MEM_W    = 3'b011,
        MEM_HU   = 3'b101,
        MEM_BU   = 3'b110
    } mem_op_t;

    typedef struct packed {
        logic       tlbsrch;
        logic       tlbrd;
        logic       tlbwr;
        logic       tlbfill;
        logic       invtlb;
        logic       found;
        logic [3:0] index;
    } tlb_op_t;

    typedef struct packed {
        logic                   gr_we;
        logic                   res_from_mem;
        mem_op_t                mem_op;
        logic [1:0]             addr_low2;
        logic [`MEM_REG_AW-1:0] dest;
        logic [`MEM_DATA_W-1:0] pc;
        logic [`MEM_DATA_W-1:0] inst;
        logic [`MEM_DATA_W-1:0] alu_result;
        csr_pkg::csr_wr_t       csr;
        csr_pkg::exc_t          exc;
        tlb_op_t                tlb;
    } ex_mem_bus_t;

    typedef struct packed {
        logic                   gr_we;
        logic                   res_from_mem;
        logic [`MEM_REG_AW-1:0] dest;
        logic [`MEM_DATA_W-1:0] pc;
        logic [`MEM_DATA_W-1:0] inst;
        logic [`MEM_DATA_W-1:0] final_result;
        csr_pkg::csr_wr_t       csr;
        csr_pkg::exc_t          exc;       // ex already qualified by valid
        tlb_op_t                tlb;
    } mem_wb_bus_t;

    typedef struct packed {
        logic                   bypass;
        logic                   load_pending;
        logic [`MEM_REG_AW-1:0] dest;
        logic [`MEM_DATA_W-1:0] final_result;
        logic                   gr_we;
        logic                   csr_re;
        csr_pkg::csr_num_t      csr_num;
    } mem_fwd_t;

endpackage

`default_nettype wire

//--- src/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic ex_mem_valid,
    input  wire logic wb_allowin,
    input  wire logic wb_ex,
    input  wire logic ertn_flush,
    input  wire logic data_ok,
    input  wire logic mem_access,
    input  wire logic item_exc,
    output logic      stage_valid,
    output logic      ready_go,
    output logic      mem_allowin,
    output logic      mem_wb_valid,
    output logic      load_en,
    output logic      buf_capture,
    output logic      buf_valid
);

    logic cancel;
    logic discard;
    logic waiting;

    assign cancel = wb_ex | ertn_flush;

    // a memory item needs its response unless it already faulted
    assign waiting = mem_access & ~item_exc;

    assign ready_go = waiting ? ((data_ok | buf_valid) & ~discard) : 1'b1;

    assign mem_wb_valid = stage_valid & ready_go & ~cancel;
    assign mem_allowin  = ~stage_valid | (mem_wb_valid & wb_allowin);
    assign load_en      = ex_mem_valid & mem_allowin;

    // response accepted but writeback not taking it this cycle
    assign buf_capture = data_ok & ~discard & ~buf_valid & ~wb_allowin
                       & stage_valid & mem_access;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (cancel) begin
            stage_valid <= 1'b0;
        end else if (mem_allowin) begin
            stage_valid <= ex_mem_valid;
        end
    end

    // the response of a flushed access is still on its way
    always_ff @(posedge clk) begin
        if (!resetn) begin
            discard <= 1'b0;
        end else if (cancel && stage_valid && waiting && !ready_go) begin
            discard <= 1'b1;
        end else if (data_ok && discard) begin
            discard <= 1'b0;                          // stale response dropped
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (cancel) begin
            buf_valid <= 1'b0;
        end else if (buf_capture) begin
            buf_valid <= 1'b1;
        end else if (buf_valid && mem_wb_valid && wb_allowin) begin
            buf_valid <= 1'b0;                        // item left with buffered word
        end
    end

endmodule

`default_nettype wire

//--- src/mem_load_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_load_unit (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire logic                   buf_capture,
    input  wire logic                   buf_valid,
    input  wire logic [`MEM_DATA_W-1:0] rdata,
    input  wire mem_pkg::mem_op_t       mem_op,
    input  wire logic [1:0]             addr_low2,
    input  wire logic                   res_from_mem,
    input  wire logic [`MEM_DATA_W-1:0] alu_result,
    output logic      [`MEM_DATA_W-1:0] final_result
);

    logic [`MEM_DATA_W-1:0] buf_data;
    logic [`MEM_DATA_W-1:0] word;
    logic [15:0]            half;
    logic [7:0]             byte_data;
    logic [`MEM_DATA_W-1:0] load_data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_data <= '0;
        end else if (buf_capture) begin
            buf_data <= rdata;
        end
    end

    assign word = buf_valid ? buf_data : rdata;

    assign half = addr_low2[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (addr_low2)
            2'b00:   byte_data = word[7:0];
            2'b01:   byte_data = word[15:8];
            2'b10:   byte_data = word[23:16];
            default: byte_data = word[31:24];
        endcase
    end

    always_comb begin
        case (mem_op)
            mem_pkg::MEM_H:  load_data = {{16{half[15]}}, half};
            mem_pkg::MEM_B:  load_data = {{24{byte_data[7]}}, byte_data};
            mem_pkg::MEM_HU: load_data = {16'b0, half};
            mem_pkg::MEM_BU: load_data = {24'b0, byte_data};
            default:         load_data = word;        // ld.w
        endcase
    end

    assign final_result = res_from_mem ? load_data : alu_result;

endmodule

`default_nettype wire

//--- src/mem_fwd.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_fwd (
    input  wire logic                   stage_valid,
    input  wire logic                   gr_we,
    input  wire logic                   res_from_mem,
    input  wire logic [`MEM_REG_AW-1:0] dest,
    input  wire logic [`MEM_DATA_W-1:0] final_result,
    input  wire csr_pkg::csr_wr_t       csr,
    input  wire logic                   tlbrd,
    output mem_pkg::mem_fwd_t           mem_fwd,
    output logic                        tlbsrch_conflict
);

    logic csr_conflict;

    assign mem_fwd.bypass       = stage_valid & gr_we;
    assign mem_fwd.load_pending = stage_valid & res_from_mem;
    assign mem_fwd.dest         = dest;
    assign mem_fwd.final_result = final_result;
    assign mem_fwd.gr_we        = gr_we;
    assign mem_fwd.csr_re       = stage_valid & csr.re;
    assign mem_fwd.csr_num      = csr.num;

    // tlbsrch reads ASID and TLBEHI
    assign csr_conflict = csr.we & ((csr.num == `CSR_ASID) | (csr.num == `CSR_TLBEHI));

    assign tlbsrch_conflict = stage_valid & (csr_conflict | tlbrd);

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_stage (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire logic                   ex_mem_valid,
    input  wire mem_pkg::ex_mem_bus_t   ex_mem_bus,
    output logic                        mem_allowin,
    output logic                        mem_wb_valid,
    output mem_pkg::mem_wb_bus_t        mem_wb_bus,
    input  wire logic                   wb_allowin,
    input  wire logic                   data_ok,
    input  wire logic [`MEM_DATA_W-1:0] rdata,
    input  wire logic                   wb_ex,
    input  wire logic                   ertn_flush,
    output mem_pkg::mem_fwd_t           mem_fwd,
    output logic                        mem_ex,
    output logic                        mem_ertn,
    output logic                        tlbsrch_conflict
);

    mem_pkg::ex_mem_bus_t   bus_q;
    logic                   stage_valid;
    logic                   ready_go;
    logic                   load_en;
    logic                   buf_capture;
    logic                   buf_valid;
    logic                   mem_access;
    logic [`MEM_DATA_W-1:0] final_result;

    always_ff @(posedge clk) begin
        if (load_en) begin
            bus_q <= ex_mem_bus;
        end
    end

    assign mem_access = (bus_q.mem_op != mem_pkg::MEM_NONE);  // loads and stores

    mem_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .ex_mem_valid (ex_mem_valid),
        .wb_allowin   (wb_allowin),
        .wb_ex        (wb_ex),
        .ertn_flush   (ertn_flush),
        .data_ok      (data_ok),
        .mem_access   (mem_access),
        .item_exc     (bus_q.exc.ex),
        .stage_valid  (stage_valid),
        .ready_go     (ready_go),
        .mem_allowin  (mem_allowin),
        .mem_wb_valid (mem_wb_valid),
        .load_en      (load_en),
        .buf_capture  (buf_capture),
        .buf_valid    (buf_valid)
    );

    mem_load_unit u_load (
        .clk          (clk),
        .resetn       (resetn),
        .buf_capture  (buf_capture),
        .buf_valid    (buf_valid & ready_go),
        .rdata        (rdata),
        .mem_op       (bus_q.mem_op),
        .addr_low2    (bus_q.addr_low2),
        .res_from_mem (bus_q.res_from_mem),
        .alu_result   (bus_q.alu_result),
        .final_result (final_result)
    );

    mem_fwd u_fwd (
        .stage_valid      (stage_valid),
        .gr_we            (bus_q.gr_we),
        .res_from_mem     (bus_q.res_from_mem),
        .dest             (bus_q.dest),
        .final_result     (final_result),
        .csr              (bus_q.csr),
        .tlbrd            (bus_q.tlb.tlbrd),
        .mem_fwd          (mem_fwd),
        .tlbsrch_conflict (tlbsrch_conflict)
    );

    assign mem_ex   = stage_valid & bus_q.exc.ex;
    assign mem_ertn = stage_valid & bus_q.exc.ertn;

    always_comb begin
        mem_wb_bus.gr_we        = bus_q.gr_we;
        mem_wb_bus.res_from_mem = bus_q.res_from_mem;
        mem_wb_bus.dest         = bus_q.dest;
        mem_wb_bus.pc           = bus_q.pc;
        mem_wb_bus.inst         = bus_q.inst;
        mem_wb_bus.final_result = final_result;
        mem_wb_bus.csr          = bus_q.csr;
        mem_wb_bus.exc          = bus_q.exc;
        mem_wb_bus.exc.ex       = mem_ex;           // stale bundle must not trap
        mem_wb_bus.tlb          = bus_q.tlb;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_stage;

    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   resetn;
    logic                   ex_mem_valid;
    mem_pkg::ex_mem_bus_t   ex_mem_bus;
    logic                   mem_allowin;
    logic                   mem_wb_valid;
    mem_pkg::mem_wb_bus_t   mem_wb_bus;
    logic                   wb_allowin;
    logic                   data_ok;
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   wb_ex;
    logic                   ertn_flush;
    mem_pkg::mem_fwd_t      mem_fwd;
    logic                   mem_ex;
    logic                   mem_ertn;
    logic                   tlbsrch_conflict;

    int          errors;
    int          timeouts;

    mem_stage u_dut (
        .clk              (clk),
        .resetn           (resetn),
        .ex_mem_valid     (ex_mem_valid),
        .ex_mem_bus       (ex_mem_bus),
        .mem_allowin      (mem_allowin),
        .mem_wb_valid     (mem_wb_valid),
        .mem_wb_bus       (mem_wb_bus),
        .wb_allowin       (wb_allowin),
        .data_ok          (data_ok),
        .rdata            (rdata),
        .wb_ex            (wb_ex),
        .ertn_flush       (ertn_flush),
        .mem_fwd          (mem_fwd),
        .mem_ex           (mem_ex),
        .mem_ertn         (mem_ertn),
        .tlbsrch_conflict (tlbsrch_conflict)
    );

    always #2 clk = ~clk;

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    // shifts the addressed part down and extends it
    function automatic logic [31:0] expect_load(input mem_pkg::mem_op_t op,
                                                input logic [1:0] off,
                                                input logic [31:0] w);
        logic [31:0] by_byte;
        logic [31:0] by_half;
        by_byte = w >> {off, 3'b000};
        by_half = w >> {off[1], 4'b0000};
        case (op)
            mem_pkg::MEM_B:  return {{24{by_byte[7]}}, by_byte[7:0]};
            mem_pkg::MEM_BU: return {24'b0, by_byte[7:0]};
            mem_pkg::MEM_H:  return {{16{by_half[15]}}, by_half[15:0]};
            mem_pkg::MEM_HU: return {16'b0, by_half[15:0]};
            default:         return w;
        endcase
    endfunction

    function automatic mem_pkg::ex_mem_bus_t plain_bundle();
        mem_pkg::ex_mem_bus_t b;
        b            = '0;
        b.gr_we      = 1'b1;
        b.dest       = 5'($urandom_range(1, 31));
        b.pc         = $urandom();
        b.inst       = $urandom();
        b.alu_result = $urandom();
        return b;
    endfunction

    // starts and ends on a falling edge
    task automatic send_bundle(input mem_pkg::ex_mem_bus_t b);
        int cnt;
        cnt          = 0;
        ex_mem_valid = 1'b1;
        ex_mem_bus   = b;
        #1;
        while (!mem_allowin && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!mem_allowin) begin
            $display("timeout: the stage never accepted the bundle with pc %h", b.pc);
            timeouts++;
        end
        @(negedge clk);
        ex_mem_valid = 1'b0;
    endtask

    task automatic run_load(input mem_pkg::mem_op_t op, input logic [1:0] off,
                            input logic from_mem);
        mem_pkg::ex_mem_bus_t b;
        logic [31:0]          word;
        logic [31:0]          expected;
        int                   lat;
        b              = plain_bundle();
        b.mem_op       = op;
        b.addr_low2    = off;
        b.res_from_mem = from_mem;
        b.gr_we        = from_mem;
        word           = $urandom();
        lat            = $urandom_range(0, 2);
        expected       = from_mem ? expect_load(op, off, word) : b.alu_result;
        send_bundle(b);
        repeat (lat) begin
            #1;
            if (mem_wb_valid) note_mismatch($sformatf("op %s left before data_ok", op.name()));
            @(negedge clk);
        end
        data_ok = 1'b1;
        rdata   = word;
        #1;
        if (!mem_wb_valid) begin
            note_mismatch($sformatf("op %s not ready in its data_ok cycle", op.name()));
        end else if (mem_wb_bus.final_result !== expected) begin
            note_mismatch($sformatf("op %s off %0d word %h: got %h, expected %h",
                                    op.name(), off, word, mem_wb_bus.final_result, expected));
        end
        if (mem_fwd.load_pending !== from_mem) note_mismatch("load_pending != res_from_mem");
        @(negedge clk);
        data_ok = 1'b0;
        rdata   = $urandom();
    endtask

    task automatic check_reset_state();
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("mem_wb_valid high after reset");
        if (mem_ex !== 1'b0) note_mismatch("mem_ex high after reset");
        if (mem_ertn !== 1'b0) note_mismatch("mem_ertn high after reset");
        if (mem_allowin !== 1'b1) note_mismatch("mem_allowin low after reset");
        @(negedge clk);
    endtask

    task automatic check_pass_through();
        mem_pkg::ex_mem_bus_t b;
        b       = plain_bundle();
        b.gr_we = 1'($urandom_range(0, 1));
        send_bundle(b);
        #1;
        if (mem_wb_valid !== 1'b1) note_mismatch("non-memory item not valid after one cycle");
        if (mem_wb_bus.final_result !== b.alu_result) note_mismatch("final_result != alu_result");
        if (mem_wb_bus.pc !== b.pc) note_mismatch("pc changed in the stage");
        if (mem_wb_bus.dest !== b.dest) note_mismatch("dest changed in the stage");
        if (mem_fwd.bypass !== b.gr_we) note_mismatch("forwarding bypass != gr_we");
        if (mem_fwd.gr_we !== b.gr_we) note_mismatch("forwarding gr_we != gr_we");
        if (mem_fwd.dest !== b.dest) note_mismatch("forwarding dest != dest");
        if (mem_fwd.final_result !== b.alu_result) note_mismatch("forwarding result wrong");
        @(negedge clk);
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("non-memory item stayed after one cycle");
        if (mem_fwd.bypass !== 1'b0) note_mismatch("bypass high with an empty stage");
        @(negedge clk);
    endtask

    task automatic check_load_extension();
        mem_pkg::mem_op_t ops [5];
        ops = '{mem_pkg::MEM_B, mem_pkg::MEM_BU, mem_pkg::MEM_H, mem_pkg::MEM_HU, mem_pkg::MEM_W};
        foreach (ops[k]) begin
            for (int i = 0; i < 4; i++) begin
                run_load(ops[k], 2'(i), 1'b1);
            end
        end
        run_load(mem_pkg::MEM_W, 2'b00, 1'b0);  // stores report alu_result
        run_load(mem_pkg::MEM_B, 2'b11, 1'b0);
    endtask

    task automatic check_back_pressure();
        mem_pkg::ex_mem_bus_t b;
        logic [31:0]          first;
        b              = plain_bundle();
        b.mem_op       = mem_pkg::MEM_H;
        b.addr_low2    = 2'b10;
        b.res_from_mem = 1'b1;
        first          = $urandom();
        wb_allowin     = 1'b0;
        send_bundle(b);
        data_ok = 1'b1;
        rdata   = first;
        #1;
        if (mem_allowin !== 1'b0) note_mismatch("mem_allowin high while writeback stalls");
        @(negedge clk);
        data_ok = 1'b0;
        rdata   = ~first;                       // SRAM moves on
        repeat (3) begin
            #1;
            if (mem_allowin !== 1'b0) note_mismatch("mem_allowin high during the stall");
            if (mem_wb_valid !== 1'b1) note_mismatch("buffered item not ready");
            @(negedge clk);
        end
        wb_allowin = 1'b1;
        #1;
        if (mem_wb_valid !== 1'b1) begin
            note_mismatch("stalled item not valid after wb_allowin rose");
        end else if (mem_wb_bus.final_result !== expect_load(mem_pkg::MEM_H, 2'b10, first)) begin
            note_mismatch($sformatf("buffered result %h, expected from word %h",
                                    mem_wb_bus.final_result, first));
        end
        @(negedge clk);
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("stalled item did not leave");
        @(negedge clk);
    endtask

    task automatic check_cancel();
        mem_pkg::ex_mem_bus_t a;
        mem_pkg::ex_mem_bus_t b;
        logic [31:0]          own;
        a              = plain_bundle();
        a.mem_op       = mem_pkg::MEM_W;
        a.res_from_mem = 1'b1;
        b              = plain_bundle();
        b.mem_op       = mem_pkg::MEM_BU;
        b.addr_low2    = 2'b11;
        b.res_from_mem = 1'b1;
        own            = $urandom();
        send_bundle(a);
        wb_ex = 1'b1;
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("cancelled load valid in the flush cycle");
        @(negedge clk);
        wb_ex = 1'b0;
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("cancelled load still valid");
        if (mem_allowin !== 1'b1) note_mismatch("stage not emptied by wb_ex");
        @(negedge clk);
        send_bundle(b);
        data_ok = 1'b1;
        rdata   = $urandom();                   // late response of the flushed load
        #1;
        if (mem_wb_valid !== 1'b0) note_mismatch("stale response was used");
        @(negedge clk);
        rdata = own;
        #1;
        if (mem_wb_valid !== 1'b1) begin
            note_mismatch("load after cancel not ready on its own response");
        end else if (mem_wb_bus.final_result !== expect_load(mem_pkg::MEM_BU, 2'b11, own)) begin
            note_mismatch($sformatf("load after cancel gave %h", mem_wb_bus.final_result));
        end
        @(negedge clk);
        data_ok = 1'b0;
    endtask

    task automatic check_conflict(input logic [13:0] num, input logic we, input logic tlbrd,
                                  input logic expected);
        mem_pkg::ex_mem_bus_t b;
        b           = plain_bundle();
        b.csr.we    = we;
        b.csr.re    = 1'b1;
        b.csr.num   = num;
        b.tlb.tlbrd = tlbrd;
        send_bundle(b);
        #1;
        if (tlbsrch_conflict !== expected) begin
            note_mismatch($sformatf("conflict %b for csr %h tlbrd %b", tlbsrch_conflict, num,
                                    tlbrd));
        end
        if (mem_fwd.csr_re !== 1'b1 || mem_fwd.csr_num !== num) begin
            note_mismatch($sformatf("csr read forwarding wrong for csr %h", num));
        end
        @(negedge clk);
    endtask

    task automatic check_exception();
        mem_pkg::ex_mem_bus_t b;
        b              = plain_bundle();
        b.mem_op       = mem_pkg::MEM_W;
        b.res_from_mem = 1'b1;
        b.exc.ex       = 1'b1;
        b.exc.ecode    = 6'h08;
        send_bundle(b);
        #1;
        if (mem_wb_valid !== 1'b1) note_mismatch("faulting item waited for data_ok");
        if (mem_ex !== 1'b1) note_mismatch("mem_ex low for a faulting item");
        if (mem_wb_bus.exc.ex !== 1'b1) note_mismatch("exception flag lost in mem_wb_bus");
        @(negedge clk);
        #1;
        if (mem_ex !== 1'b0) note_mismatch("mem_ex stayed high after the item left");
        @(negedge clk);
        b          = plain_bundle();
        b.exc.ertn = 1'b1;
        send_bundle(b);
        #1;
        if (mem_ertn !== 1'b1) note_mismatch("mem_ertn low for an ertn item");
        if (mem_ex !== 1'b0) note_mismatch("mem_ex high for an ertn item");
        @(negedge clk);
        #1;
        if (mem_ertn !== 1'b0) note_mismatch("mem_ertn stayed high after the item left");
        @(negedge clk);
        check_conflict(`CSR_ASID, 1'b1, 1'b0, 1'b1);
        check_conflict(`CSR_TLBEHI, 1'b1, 1'b0, 1'b1);
        check_conflict(14'h10, 1'b0, 1'b1, 1'b1);
        check_conflict(14'h10, 1'b1, 1'b0, 1'b0);   // unrelated CSR
    endtask

    initial begin
        void'($urandom(32'h4fcf_4343));
        errors       = 0;
        timeouts     = 0;
        clk          = 1'b0;
        resetn       = 1'b0;
        ex_mem_valid = 1'b0;
        ex_mem_bus   = '0;
        wb_allowin   = 1'b1;
        data_ok      = 1'b0;
        rdata        = '0;
        wb_ex        = 1'b0;
        ertn_flush   = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_reset_state();
        check_pass_through();
        check_load_extension();
        check_back_pressure();
        check_cancel();
        check_exception();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/csr_pkg.sv
src/mem_pkg.sv
src/mem_ctrl.sv
src/mem_load_unit.sv
src/mem_fwd.sv
src/mem_stage.sv
testbench/tb_mem_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mem_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
